/* verilog.f */
+incdir+verilog
+incdir+tests
verilog/geom_pkg.sv
verilog/setup_ctrl_pkg.sv
verilog/raster_ifs.sv
verilog/edge_compute.sv
verilog/bounding_box.sv
verilog/setup_controller.sv
verilog/rasterizer_frontend.sv
tests/tb_rasterizer_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rasterizer front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_rasterizer_frontend \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* tests/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`include "raster_defs.svh"

// Smallest of three coordinates
function automatic int ref_lo(input int a, input int b, input int c);
    int r;
    r = a;
    if (b < r) begin
        r = b;
    end
    if (c < r) begin
        r = c;
    end
    return r;
endfunction

// Largest of three coordinates
function automatic int ref_hi(input int a, input int b, input int c);
    int r;
    r = a;
    if (b > r) begin
        r = b;
    end
    if (c > r) begin
        r = c;
    end
    return r;
endfunction

// Limit a box coordinate to 0 .. hi
function automatic int ref_clamp(input int v, input int hi);
    if (v < 0) begin
        return 0;
    end
    if (v > hi) begin
        return hi;
    end
    return v;
endfunction

// Cross product of (p - a) and (b - a)
function automatic int ref_edge(input int ax, ay, bx, by, px, py);
    return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
endfunction

// Edge value change for one step in x and in y
function automatic int ref_step_x(input int ay, input int by);
    return by - ay;
endfunction

function automatic int ref_step_y(input int ax, input int bx);
    return ax - bx;
endfunction

// Non-positive area, or a box that misses the screen
function automatic bit ref_culled(input int ax, ay, bx, by, cx, cy);
    int  area;
    bit  visible;
    area    = ref_edge(ax, ay, bx, by, cx, cy);
    visible = (ref_hi(ax, bx, cx) >= 0) && (ref_lo(ax, bx, cx) <= `RASTER_SCREEN_W) &&
              (ref_hi(ay, by, cy) >= 0) && (ref_lo(ay, by, cy) <= `RASTER_SCREEN_H);
    return (area <= 0) || !visible;
endfunction

`endif

/* tests/tb_rasterizer_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rasterizer_frontend;

    `include "tb_ref_model.svh"

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TRIANGLES   = 28;
    localparam int WATCHDOG_CYCLES = NUM_TRIANGLES * 40 + RESET_CYCLES;
    localparam int WAIT_LIMIT      = 30;
    localparam int STALL_CYCLES    = 10;
    localparam int ID_MOD          = 1 << `RASTER_ID_W;
    // o_dv is set on the sixth edge counting the accepting one
    localparam int DV_LATENCY      = 5;

    logic                    clk;
    logic                    rstn;
    geom_pkg::coord_t        i_v0_x;
    geom_pkg::coord_t        i_v0_y;
    geom_pkg::coord_t        i_v1_x;
    geom_pkg::coord_t        i_v1_y;
    geom_pkg::coord_t        i_v2_x;
    geom_pkg::coord_t        i_v2_y;
    logic                    i_triangle_dv;
    logic                    i_triangle_last;
    logic                    i_next;
    logic                    o_ready;
    geom_pkg::coord_t        o_bb_min_x;
    geom_pkg::coord_t        o_bb_min_y;
    geom_pkg::coord_t        o_bb_max_x;
    geom_pkg::coord_t        o_bb_max_y;
    geom_pkg::edge_val_t     o_edge_val0;
    geom_pkg::edge_val_t     o_edge_val1;
    geom_pkg::edge_val_t     o_edge_val2;
    geom_pkg::coord_t        o_edge_dx0;
    geom_pkg::coord_t        o_edge_dy0;
    geom_pkg::coord_t        o_edge_dx1;
    geom_pkg::coord_t        o_edge_dy1;
    geom_pkg::coord_t        o_edge_dx2;
    geom_pkg::coord_t        o_edge_dy2;
    setup_ctrl_pkg::tri_id_t o_id;
    logic                    o_dv;
    logic                    o_last;
    logic                    o_finished_with_cull;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     err_at_start;
    string  test_name;
    int     exp_id;
    int     dv_count;
    int     fin_count;
    int     dv_edges;

    rasterizer_frontend i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_coord(input string field, input geom_pkg::coord_t exp,
                               input geom_pkg::coord_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic check_edge(input string field, input geom_pkg::edge_val_t exp,
                              input geom_pkg::edge_val_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic check_id(input string field, input setup_ctrl_pkg::tri_id_t exp,
                            input setup_ctrl_pkg::tri_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic check_bit(input string field, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %0b, actual %0b", test_name, field, exp, act);
        end
    endtask

    task automatic check_count(input string field, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == err_at_start) begin
            $display("%s: pass", test_name);
        end else begin
            $display("%s: fail, %0d errors", test_name, errors - err_at_start);
        end
    endtask

    function automatic int rand_coord();
        int r;
        r = {$random(seed)} % 401;
        return r - 40;
    endfunction

    // Returns on the accepting edge
    task automatic accept_triangle(input int ax, ay, bx, by, cx, cy, input bit is_last);
        int n;
        n = 0;
        @(negedge clk);
        while (!o_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_ready) begin
            report_failure("the DUT never became ready for a new triangle");
        end
        @(posedge clk);
        i_v0_x          <= geom_pkg::coord_t'(ax);
        i_v0_y          <= geom_pkg::coord_t'(ay);
        i_v1_x          <= geom_pkg::coord_t'(bx);
        i_v1_y          <= geom_pkg::coord_t'(by);
        i_v2_x          <= geom_pkg::coord_t'(cx);
        i_v2_y          <= geom_pkg::coord_t'(cy);
        i_triangle_dv   <= 1'b1;
        i_triangle_last <= is_last;
        @(posedge clk);
        i_triangle_dv   <= 1'b0;
        i_triangle_last <= 1'b0;
        exp_id = (exp_id + 1) % ID_MOD;
    endtask

    task automatic note_outputs(input int n);
        if (o_dv) begin
            if (dv_count == 0) begin
                dv_edges = n;
            end
            dv_count++;
        end
        if (o_finished_with_cull) begin
            fin_count++;
        end
    endtask

    // Follows the DUT back to IDLE, plus one cycle to catch stray pulses
    task automatic wait_result();
        int n;
        n         = 0;
        dv_count  = 0;
        fin_count = 0;
        dv_edges  = -1;
        @(negedge clk);
        note_outputs(n);
        while (!o_ready && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            note_outputs(n);
        end
        if (!o_ready) begin
            report_failure("timed out waiting for the DUT to finish the triangle");
        end
        @(posedge clk);
        @(negedge clk);
        note_outputs(n + 1);
    endtask

    task automatic check_kept(input int ax, ay, bx, by, cx, cy, input bit is_last);
        int lx;
        int ly;
        int hx;
        int hy;
        lx = ref_clamp(ref_lo(ax, bx, cx), `RASTER_SCREEN_W);
        ly = ref_clamp(ref_lo(ay, by, cy), `RASTER_SCREEN_H);
        hx = ref_clamp(ref_hi(ax, bx, cx), `RASTER_SCREEN_W);
        hy = ref_clamp(ref_hi(ay, by, cy), `RASTER_SCREEN_H);
        check_coord("o_bb_min_x", geom_pkg::coord_t'(lx), o_bb_min_x);
        check_coord("o_bb_min_y", geom_pkg::coord_t'(ly), o_bb_min_y);
        check_coord("o_bb_max_x", geom_pkg::coord_t'(hx), o_bb_max_x);
        check_coord("o_bb_max_y", geom_pkg::coord_t'(hy), o_bb_max_y);
        check_edge("o_edge_val0", geom_pkg::edge_val_t'(ref_edge(ax, ay, bx, by, lx, ly)),
                   o_edge_val0);
        check_edge("o_edge_val1", geom_pkg::edge_val_t'(ref_edge(bx, by, cx, cy, lx, ly)),
                   o_edge_val1);
        check_edge("o_edge_val2", geom_pkg::edge_val_t'(ref_edge(cx, cy, ax, ay, lx, ly)),
                   o_edge_val2);
        check_coord("o_edge_dx0", geom_pkg::coord_t'(ref_step_x(ay, by)), o_edge_dx0);
        check_coord("o_edge_dy0", geom_pkg::coord_t'(ref_step_y(ax, bx)), o_edge_dy0);
        check_coord("o_edge_dx1", geom_pkg::coord_t'(ref_step_x(by, cy)), o_edge_dx1);
        check_coord("o_edge_dy1", geom_pkg::coord_t'(ref_step_y(bx, cx)), o_edge_dy1);
        check_coord("o_edge_dx2", geom_pkg::coord_t'(ref_step_x(cy, ay)), o_edge_dx2);
        check_coord("o_edge_dy2", geom_pkg::coord_t'(ref_step_y(cx, ax)), o_edge_dy2);
        check_id("o_id", setup_ctrl_pkg::tri_id_t'(exp_id), o_id);
        check_bit("o_last", is_last, o_last);
    endtask

    task automatic finish_triangle(input int ax, ay, bx, by, cx, cy, input bit is_last);
        bit exp_culled;
        exp_culled = ref_culled(ax, ay, bx, by, cx, cy);
        wait_result();
        check_count("o_dv pulses", exp_culled ? 0 : 1, dv_count);
        check_count("o_finished_with_cull pulses", (exp_culled && is_last) ? 1 : 0, fin_count);
        if (!exp_culled) begin
            check_kept(ax, ay, bx, by, cx, cy, is_last);
        end
        if (is_last) begin
            exp_id = 0;
        end
    endtask

    task automatic run_triangle(input int ax, ay, bx, by, cx, cy, input bit is_last);
        accept_triangle(ax, ay, bx, by, cx, cy, is_last);
        finish_triangle(ax, ay, bx, by, cx, cy, is_last);
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        @(negedge clk);
        check_bit("o_ready", 1'b1, o_ready);
        check_bit("o_dv", 1'b0, o_dv);
        check_bit("o_last", 1'b0, o_last);
        check_bit("o_finished_with_cull", 1'b0, o_finished_with_cull);
        end_test();
    endtask

    task automatic test_kept_triangle();
        begin_test("kept_triangle");
        run_triangle(10, 10, 40, 90, 100, 20, 1'b1);
        check_count("o_dv latency", DV_LATENCY, dv_edges);
        end_test();
    endtask

    task automatic test_back_pressure();
        begin_test("back_pressure");
        @(posedge clk);
        i_next <= 1'b0;
        accept_triangle(50, 50, 60, 200, 200, 60, 1'b0);
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_bit("o_dv while stalled", 1'b0, o_dv);
            check_bit("o_ready while stalled", 1'b0, o_ready);
        end
        @(posedge clk);
        i_next <= 1'b1;
        finish_triangle(50, 50, 60, 200, 200, 60, 1'b0);
        end_test();
    endtask

    task automatic test_culling();
        begin_test("culling");
        // Clockwise, collinear, then entirely past the right and bottom edges
        run_triangle(10, 10, 100, 20, 40, 90, 1'b0);
        run_triangle(10, 10, 50, 50, 90, 90, 1'b0);
        run_triangle(400, 400, 400, 500, 500, 400, 1'b0);
        run_triangle(20, 20, 120, 30, 50, 100, 1'b1);
        // Id restarts after the culled last triangle
        run_triangle(10, 10, 40, 90, 100, 20, 1'b0);
        check_id("o_id after culled last", setup_ctrl_pkg::tri_id_t'(1), o_id);
        end_test();
    endtask

    task automatic test_clamping();
        begin_test("clamping");
        run_triangle(-20, -30, 100, 350, 350, 100, 1'b1);
        check_coord("o_bb_min_x clamped", geom_pkg::coord_t'(0), o_bb_min_x);
        check_coord("o_bb_min_y clamped", geom_pkg::coord_t'(0), o_bb_min_y);
        check_coord("o_bb_max_x clamped", geom_pkg::coord_t'(`RASTER_SCREEN_W), o_bb_max_x);
        check_coord("o_bb_max_y clamped", geom_pkg::coord_t'(`RASTER_SCREEN_H), o_bb_max_y);
        end_test();
    endtask

    task automatic test_random_batch();
        int ax;
        int ay;
        int bx;
        int by;
        int cx;
        int cy;
        begin_test("random_batch");
        for (int k = 0; k < 20; k++) begin
            ax = rand_coord();
            ay = rand_coord();
            bx = rand_coord();
            by = rand_coord();
            cx = rand_coord();
            cy = rand_coord();
            run_triangle(ax, ay, bx, by, cx, cy, k == 19);
        end
        end_test();
    endtask

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        i_v0_x          = '0;
        i_v0_y          = '0;
        i_v1_x          = '0;
        i_v1_y          = '0;
        i_v2_x          = '0;
        i_v2_y          = '0;
        i_triangle_dv   = 1'b0;
        i_triangle_last = 1'b0;
        i_next          = 1'b1;
        seed            = 89;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        exp_id          = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        test_reset_state();
        test_kept_triangle();
        test_back_pressure();
        test_culling();
        test_clamping();
        test_random_batch();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/rasterizer_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterizer_frontend (
    input  wire logic                     clk,
    input  wire logic                     rstn,

    input  wire geom_pkg::coord_t         i_v0_x,
    input  wire geom_pkg::coord_t         i_v0_y,
    input  wire geom_pkg::coord_t         i_v1_x,
    input  wire geom_pkg::coord_t         i_v1_y,
    input  wire geom_pkg::coord_t         i_v2_x,
    input  wire geom_pkg::coord_t         i_v2_y,
    input  wire logic                     i_triangle_dv,
    input  wire logic                     i_triangle_last,
    input  wire logic                     i_next,
    output logic                          o_ready,

    output geom_pkg::coord_t              o_bb_min_x,
    output geom_pkg::coord_t              o_bb_min_y,
    output geom_pkg::coord_t              o_bb_max_x,
    output geom_pkg::coord_t              o_bb_max_y,
    output geom_pkg::edge_val_t           o_edge_val0,
    output geom_pkg::edge_val_t           o_edge_val1,
    output geom_pkg::edge_val_t           o_edge_val2,
    output geom_pkg::coord_t              o_edge_dx0,
    output geom_pkg::coord_t              o_edge_dy0,
    output geom_pkg::coord_t              o_edge_dx1,
    output geom_pkg::coord_t              o_edge_dy1,
    output geom_pkg::coord_t              o_edge_dx2,
    output geom_pkg::coord_t              o_edge_dy2,

    output setup_ctrl_pkg::tri_id_t       o_id,
    output logic                          o_dv,
    output logic                          o_last,
    output logic                          o_finished_with_cull
);

    geom_pkg::point_t      v0;
    geom_pkg::point_t      v1;
    geom_pkg::point_t      v2;
    geom_pkg::point_t      box_min;
    geom_pkg::point_t      box_max;
    geom_pkg::edge_val_t   edge_val [3];
    geom_pkg::edge_delta_t edge_delta [3];

    edge_if u_edge_if ();
    bbox_if u_bbox_if ();

    assign v0 = '{x: i_v0_x, y: i_v0_y};
    assign v1 = '{x: i_v1_x, y: i_v1_y};
    assign v2 = '{x: i_v2_x, y: i_v2_y};

    setup_controller u_setup_controller (
        .clk                  (clk),
        .rstn                 (rstn),
        .i_v0                 (v0),
        .i_v1                 (v1),
        .i_v2                 (v2),
        .i_triangle_dv        (i_triangle_dv),
        .i_triangle_last      (i_triangle_last),
        .i_next               (i_next),
        .o_ready              (o_ready),
        .io_edge              (u_edge_if.ctrl),
        .io_bbox              (u_bbox_if.ctrl),
        .o_box_min            (box_min),
        .o_box_max            (box_max),
        .o_edge_val           (edge_val),
        .o_edge_delta         (edge_delta),
        .o_id                 (o_id),
        .o_dv                 (o_dv),
        .o_last               (o_last),
        .o_finished_with_cull (o_finished_with_cull)
    );

    edge_compute u_edge_compute (
        .io_edge (u_edge_if.compute)
    );

    bounding_box u_bounding_box (
        .io_bbox (u_bbox_if.box)
    );

    // Flatten results onto the plain output ports
    assign o_bb_min_x  = box_min.x;
    assign o_bb_min_y  = box_min.y;
    assign o_bb_max_x  = box_max.x;
    assign o_bb_max_y  = box_max.y;
    assign o_edge_val0 = edge_val[0];
    assign o_edge_val1 = edge_val[1];
    assign o_edge_val2 = edge_val[2];
    assign o_edge_dx0  = edge_delta[0].dx;
    assign o_edge_dy0  = edge_delta[0].dy;
    assign o_edge_dx1  = edge_delta[1].dx;
    assign o_edge_dy1  = edge_delta[1].dy;
    assign o_edge_dx2  = edge_delta[2].dx;
    assign o_edge_dy2  = edge_delta[2].dy;

endmodule

`default_nettype wire

/* verilog/setup_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module setup_controller (
    input  wire logic                     clk,
    input  wire logic                     rstn,

    input  wire geom_pkg::point_t         i_v0,
    input  wire geom_pkg::point_t         i_v1,
    input  wire geom_pkg::point_t         i_v2,
    input  wire logic                     i_triangle_dv,
    input  wire logic                     i_triangle_last,
    input  wire logic                     i_next,
    output logic                          o_ready,

    edge_if.ctrl                          io_edge,
    bbox_if.ctrl                          io_bbox,

    output geom_pkg::point_t              o_box_min,
    output geom_pkg::point_t              o_box_max,
    output geom_pkg::edge_val_t           o_edge_val [3],
    output geom_pkg::edge_delta_t         o_edge_delta [3],
    output setup_ctrl_pkg::tri_id_t       o_id,
    output logic                          o_dv,
    output logic                          o_last,
    output logic                          o_finished_with_cull
);

    setup_ctrl_pkg::setup_state_t state;
    setup_ctrl_pkg::setup_state_t state_nxt;

    geom_pkg::point_t      r_v0;
    geom_pkg::point_t      r_v1;
    geom_pkg::point_t      r_v2;
    logic                  r_last;
    setup_ctrl_pkg::tri_id_t r_id;

    geom_pkg::edge_val_t   r_area;
    geom_pkg::point_t      r_box_min;
    geom_pkg::point_t      r_box_max;
    logic                  r_on_screen;
    geom_pkg::edge_val_t   r_edge_val [3];
    geom_pkg::edge_delta_t r_edge_delta [3];

    logic                  cull;

    assign io_bbox.v0 = r_v0;
    assign io_bbox.v1 = r_v1;
    assign io_bbox.v2 = r_v2;

    // Back-facing, degenerate or entirely off screen
    assign cull = (r_area <= 0) || !r_on_screen;

    // Edge unit operands for the area and then the three edges at the box corner
    always_comb begin
        io_edge.a = r_v0;
        io_edge.b = r_v1;
        io_edge.p = r_v2;
        case (state)
            setup_ctrl_pkg::EDGE0: begin
                io_edge.p = r_box_min;
            end
            setup_ctrl_pkg::EDGE1: begin
                io_edge.a = r_v1;
                io_edge.b = r_v2;
                io_edge.p = r_box_min;
            end
            setup_ctrl_pkg::EDGE2: begin
                io_edge.a = r_v2;
                io_edge.b = r_v0;
                io_edge.p = r_box_min;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        o_ready   = 1'b0;
        case (state)
            setup_ctrl_pkg::IDLE: begin
                if (i_triangle_dv) begin
                    state_nxt = setup_ctrl_pkg::AREA;
                end else begin
                    o_ready = 1'b1;
                end
            end
            setup_ctrl_pkg::AREA: begin
                state_nxt = setup_ctrl_pkg::EDGE0;
            end
            setup_ctrl_pkg::EDGE0: begin
                // Culled triangles still wait for downstream
                if (!cull) begin
                    state_nxt = setup_ctrl_pkg::EDGE1;
                end else if (i_next) begin
                    state_nxt = setup_ctrl_pkg::IDLE;
                end
            end
            setup_ctrl_pkg::EDGE1: begin
                state_nxt = setup_ctrl_pkg::EDGE2;
            end
            setup_ctrl_pkg::EDGE2: begin
                state_nxt = setup_ctrl_pkg::DONE;
            end
            setup_ctrl_pkg::DONE: begin
                if (i_next) begin
                    state_nxt = setup_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = setup_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state                <= setup_ctrl_pkg::IDLE;
            r_id                 <= '0;
            r_last               <= 1'b0;
            o_dv                 <= 1'b0;
            o_last               <= 1'b0;
            o_finished_with_cull <= 1'b0;
        end else begin
            state                <= state_nxt;
            o_dv                 <= 1'b0;
            o_finished_with_cull <= 1'b0;
            case (state)
                setup_ctrl_pkg::IDLE: begin
                    if (i_triangle_dv) begin
                        r_id   <= r_id + setup_ctrl_pkg::tri_id_t'(1);
                        r_last <= i_triangle_last;
                    end
                end
                setup_ctrl_pkg::EDGE0: begin
                    if (cull && i_next && r_last) begin
                        o_finished_with_cull <= 1'b1;
                        r_id                 <= '0;
                    end
                end
                setup_ctrl_pkg::DONE: begin
                    if (i_next) begin
                        o_dv   <= 1'b1;
                        o_last <= r_last;
                        if (r_last) begin
                            r_id <= '0;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            setup_ctrl_pkg::IDLE: begin
                if (i_triangle_dv) begin
                    r_v0 <= i_v0;
                    r_v1 <= i_v1;
                    r_v2 <= i_v2;
                end
            end
            setup_ctrl_pkg::AREA: begin
                r_area      <= io_edge.value;
                r_box_min   <= io_bbox.box_min;
                r_box_max   <= io_bbox.box_max;
                r_on_screen <= io_bbox.on_screen;
            end
            setup_ctrl_pkg::EDGE0: begin
                r_edge_val[0]   <= io_edge.value;
                r_edge_delta[0] <= io_edge.delta;
            end
            setup_ctrl_pkg::EDGE1: begin
                r_edge_val[1]   <= io_edge.value;
                r_edge_delta[1] <= io_edge.delta;
            end
            setup_ctrl_pkg::EDGE2: begin
                r_edge_val[2]   <= io_edge.value;
                r_edge_delta[2] <= io_edge.delta;
            end
            setup_ctrl_pkg::DONE: begin
                if (i_next) begin
                    o_box_min    <= r_box_min;
                    o_box_max    <= r_box_max;
                    o_edge_val   <= r_edge_val;
                    o_edge_delta <= r_edge_delta;
                    o_id         <= r_id;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/bounding_box.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module bounding_box (
    bbox_if.box io_bbox
);

    localparam geom_pkg::coord_t LIMIT_X = geom_pkg::coord_t'(`RASTER_SCREEN_W);
    localparam geom_pkg::coord_t LIMIT_Y = geom_pkg::coord_t'(`RASTER_SCREEN_H);

    geom_pkg::coord_t min_x;
    geom_pkg::coord_t min_y;
    geom_pkg::coord_t max_x;
    geom_pkg::coord_t max_y;

    function automatic geom_pkg::coord_t min3(
        input geom_pkg::coord_t a,
        input geom_pkg::coord_t b,
        input geom_pkg::coord_t c
    );
        geom_pkg::coord_t m;
        m = (b < a) ? b : a;
        return (c < m) ? c : m;
    endfunction

    function automatic geom_pkg::coord_t max3(
        input geom_pkg::coord_t a,
        input geom_pkg::coord_t b,
        input geom_pkg::coord_t c
    );
        geom_pkg::coord_t m;
        m = (b > a) ? b : a;
        return (c > m) ? c : m;
    endfunction

    function automatic geom_pkg::coord_t clamp(
        input geom_pkg::coord_t v,
        input geom_pkg::coord_t hi
    );
        geom_pkg::coord_t r;
        if (v < 0) begin
            r = '0;
        end else if (v > hi) begin
            r = hi;
        end else begin
            r = v;
        end
        return r;
    endfunction

    // Unclamped extent of the triangle
    always_comb begin
        min_x = min3(io_bbox.v0.x, io_bbox.v1.x, io_bbox.v2.x);
        min_y = min3(io_bbox.v0.y, io_bbox.v1.y, io_bbox.v2.y);
        max_x = max3(io_bbox.v0.x, io_bbox.v1.x, io_bbox.v2.x);
        max_y = max3(io_bbox.v0.y, io_bbox.v1.y, io_bbox.v2.y);
    end

    assign io_bbox.box_min = '{x: clamp(min_x, LIMIT_X), y: clamp(min_y, LIMIT_Y)};
    assign io_bbox.box_max = '{x: clamp(max_x, LIMIT_X), y: clamp(max_y, LIMIT_Y)};

    // Box touches the screen in both axes
    assign io_bbox.on_screen = (max_x >= 0) && (min_x <= LIMIT_X) &&
                               (max_y >= 0) && (min_y <= LIMIT_Y);

endmodule

`default_nettype wire

/* verilog/edge_compute.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_compute (
    edge_if.compute io_edge
);

    geom_pkg::edge_val_t pa_x;
    geom_pkg::edge_val_t pa_y;
    geom_pkg::edge_val_t ba_x;
    geom_pkg::edge_val_t ba_y;

    // Differences sign extended first so the products keep full width
    always_comb begin
        pa_x = geom_pkg::edge_val_t'(io_edge.p.x) - geom_pkg::edge_val_t'(io_edge.a.x);
        pa_y = geom_pkg::edge_val_t'(io_edge.p.y) - geom_pkg::edge_val_t'(io_edge.a.y);
        ba_x = geom_pkg::edge_val_t'(io_edge.b.x) - geom_pkg::edge_val_t'(io_edge.a.x);
        ba_y = geom_pkg::edge_val_t'(io_edge.b.y) - geom_pkg::edge_val_t'(io_edge.a.y);
    end

    // Cross product of (p - a) and (b - a)
    assign io_edge.value = pa_x * ba_y - pa_y * ba_x;

    // Step in x adds (b.y - a.y), step in y subtracts (b.x - a.x)
    assign io_edge.delta = '{
        dx: io_edge.b.y - io_edge.a.y,
        dy: io_edge.a.x - io_edge.b.x
    };

endmodule

`default_nettype wire

/* verilog/raster_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Shared edge function unit
interface edge_if;
    geom_pkg::point_t      a;
    geom_pkg::point_t      b;
    geom_pkg::point_t      p;
    geom_pkg::edge_val_t   value;
    geom_pkg::edge_delta_t delta;

    modport ctrl (
        output a, b, p,
        input  value, delta
    );

    modport compute (
        input  a, b, p,
        output value, delta
    );
endinterface

// Bounding box of the registered vertices
interface bbox_if;
    geom_pkg::point_t v0;
    geom_pkg::point_t v1;
    geom_pkg::point_t v2;
    geom_pkg::point_t box_min;
    geom_pkg::point_t box_max;
    logic             on_screen;

    modport ctrl (
        output v0, v1, v2,
        input  box_min, box_max, on_screen
    );

    modport box (
        input  v0, v1, v2,
        output box_min, box_max, on_screen
    );
endinterface

`default_nettype wire

/* verilog/setup_ctrl_pkg.sv */
`default_nettype none

`include "raster_defs.svh"

package setup_ctrl_pkg;

    // Setup sequence, one state per cycle except IDLE, EDGE0 and DONE
    typedef enum logic [2:0] {
        IDLE,
        AREA,
        EDGE0,
        EDGE1,
        EDGE2,
        DONE
    } setup_state_t;

    // Triangle tag, restarts after a last triangle
    typedef logic [`RASTER_ID_W-1:0] tri_id_t;

endpackage

`default_nettype wire

/* verilog/geom_pkg.sv */
`default_nettype none

`include "raster_defs.svh"

package geom_pkg;

    // One screen coordinate
    typedef logic signed [`RASTER_COORD_W-1:0] coord_t;

    // Vertex or corner, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Edge function or doubled area, full product width
    typedef logic signed [2*`RASTER_COORD_W-1:0] edge_val_t;

    // Edge value change per unit step in x and in y
    typedef struct packed {
        coord_t dx;
        coord_t dy;
    } edge_delta_t;

endpackage

`default_nettype wire

/* verilog/raster_defs.svh */
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Signed screen coordinate width
`define RASTER_COORD_W 12

// Screen limits, inclusive upper bound for clamping
`define RASTER_SCREEN_W 320
`define RASTER_SCREEN_H 320

// Triangle id width, wraps modulo 2**RASTER_ID_W
`define RASTER_ID_W 4

`endif
